// ==== verilog/pkt_macros.svh ====
`ifndef PKT_MACROS_SVH
`define PKT_MACROS_SVH

// Frame RAM address width for 256 bytes.
`define PKT_RAM_AW 8

// Leading byte of every packet.
// Not part of the checksum.
`define PKT_SYNC 8'hA5

// Packets sent per run.
// ACK, NAK, STALL, LINK, TYPE, TEMP, DATA0.
`define PKT_COUNT 7

`endif

// ==== verilog/pkt_pkg.sv ====
`include "pkt_macros.svh"

package pkt_pkg;

    // Header kind codes.
    typedef enum logic [3:0] {
        KIND_ACK   = 4'd1,
        KIND_NAK   = 4'd2,
        KIND_STALL = 4'd3,
        KIND_LINK  = 4'd8,
        KIND_TYPE  = 4'd9,
        KIND_TEMP  = 4'd10,
        KIND_DATA0 = 4'd13
    } pkt_kind_e;

    // Handshake packets.
    typedef struct packed {
        pkt_kind_e  kind;
        logic [3:0] seq;
        logic [7:0] code;
    } pkt_ctrl_hdr_t;

    // Field and payload packets.
    typedef struct packed {
        pkt_kind_e  kind;
        logic [3:0] didx;
        logic [7:0] len;
    } pkt_data_hdr_t;

    // Kind sits in the top nibble of both views.
    typedef union packed {
        pkt_ctrl_hdr_t ctrl;
        pkt_data_hdr_t data;
    } pkt_hdr_u;

    // One packet to send.
    typedef struct packed {
        pkt_hdr_u               hdr;
        logic [7:0]             field;
        logic [`PKT_RAM_AW-1:0] ram_base;
    } pkt_req_t;

endpackage

// ==== verilog/frame_ram.sv ====
`include "pkt_macros.svh"

module frame_ram (
    input  logic                   clk,
    input  logic                   wr_en,
    input  logic [`PKT_RAM_AW-1:0] wr_addr,
    input  logic [7:0]             wr_data,
    input  logic [`PKT_RAM_AW-1:0] rd_addr,
    output logic [7:0]             rd_data
);

    localparam int DEPTH = 2 ** `PKT_RAM_AW;

    logic [7:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data lags the address by one cycle.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== verilog/ram_fill.sv ====
`include "pkt_macros.svh"

module ram_fill (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fill_start,
    input  logic [7:0]             fill_seed,
    output logic                   wr_en,
    output logic [`PKT_RAM_AW-1:0] wr_addr,
    output logic [7:0]             wr_data,
    output logic                   fill_done
);

    logic                   active;
    logic                   launch;
    logic [`PKT_RAM_AW-1:0] addr;
    logic [7:0]             seed;

    assign launch = fill_start && !active;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            addr   <= '0;
        end else if (launch) begin
            active <= 1'b1;
            addr   <= '0;
        end else if (active) begin
            addr <= addr + 1'b1;
            if (addr == '1) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            seed <= fill_seed;
        end
    end

    assign wr_en     = active;
    assign wr_addr   = addr;
    assign wr_data   = 8'(addr) + seed;
    // Same cycle as the write to the top address.
    assign fill_done = active && (addr == '1);

endmodule

// ==== verilog/frame_tx.sv ====
`include "pkt_macros.svh"

module frame_tx (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   tx_start,
    input  pkt_pkg::pkt_req_t      req,
    output logic [`PKT_RAM_AW-1:0] rd_addr,
    input  logic [7:0]             rd_data,
    output logic [7:0]             txd,
    output logic                   txv,
    output logic                   tx_done
);

    // Names the byte loaded into txd at the next edge.
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_HDR_HI,
        PH_HDR_LO,
        PH_BODY,
        PH_CSUM
    } phase_e;

    phase_e             phase;
    pkt_pkg::pkt_kind_e kind;
    logic               from_ram;
    logic [7:0]         body_len;
    logic [7:0]         body_byte;
    logic [7:0]         cnt;
    logic [7:0]         csum;

    assign kind      = req.hdr.ctrl.kind;
    assign from_ram  = (kind == pkt_pkg::KIND_DATA0);
    assign body_byte = from_ram ? rd_data : req.field;

    always_comb begin
        case (kind)
            pkt_pkg::KIND_LINK,
            pkt_pkg::KIND_TYPE,
            pkt_pkg::KIND_TEMP: begin
                body_len = 8'd1;
            end
            pkt_pkg::KIND_DATA0: begin
                body_len = req.hdr.data.len;
            end
            default: begin
                body_len = 8'd0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase   <= PH_IDLE;
            txv     <= 1'b0;
            tx_done <= 1'b0;
            cnt     <= '0;
        end else begin
            txv     <= 1'b0;
            tx_done <= 1'b0;
            case (phase)
                PH_IDLE: begin
                    if (tx_start) begin
                        txv   <= 1'b1;
                        phase <= PH_HDR_HI;
                    end
                end
                PH_HDR_HI: begin
                    txv   <= 1'b1;
                    phase <= PH_HDR_LO;
                end
                PH_HDR_LO: begin
                    txv   <= 1'b1;
                    cnt   <= '0;
                    phase <= (body_len == 8'd0) ? PH_CSUM : PH_BODY;
                end
                PH_BODY: begin
                    txv <= 1'b1;
                    cnt <= cnt + 1'b1;
                    if (cnt == body_len - 8'd1) begin
                        phase <= PH_CSUM;
                    end
                end
                PH_CSUM: begin
                    txv     <= 1'b1;
                    tx_done <= 1'b1;
                    phase   <= PH_IDLE;
                end
                default: begin
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

    // Byte, checksum and read address path.
    // The RAM address runs one byte ahead of txd so the body has no gaps.
    always_ff @(posedge clk) begin
        case (phase)
            PH_IDLE: begin
                if (tx_start) begin
                    txd     <= `PKT_SYNC;
                    rd_addr <= req.ram_base;
                end
            end
            PH_HDR_HI: begin
                txd  <= req.hdr[15:8];
                csum <= req.hdr[15:8];
            end
            PH_HDR_LO: begin
                txd     <= req.hdr[7:0];
                csum    <= csum ^ req.hdr[7:0];
                rd_addr <= rd_addr + 1'b1;
            end
            PH_BODY: begin
                txd     <= body_byte;
                csum    <= csum ^ body_byte;
                rd_addr <= rd_addr + 1'b1;
            end
            PH_CSUM: begin
                txd <= csum;
            end
            default: begin
                txd <= txd;
            end
        endcase
    end

endmodule

// ==== verilog/frame_sequencer.sv ====
`include "pkt_macros.svh"

module frame_sequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [7:0]             link_id,
    input  logic [7:0]             dev_type,
    input  logic [7:0]             temp,
    input  logic [3:0]             didx,
    input  logic [7:0]             len,
    input  logic [`PKT_RAM_AW-1:0] ram_base,
    output logic                   fill_start,
    input  logic                   fill_done,
    output logic                   tx_start,
    output pkt_pkg::pkt_req_t      req,
    input  logic                   tx_done,
    output logic                   busy,
    output logic                   done
);

    typedef enum logic [4:0] {
        ST_IDLE, ST_FILL,
        ST_PACK, ST_WACK, ST_PNAK, ST_WNAK, ST_PSTALL, ST_WSTALL,
        ST_PLINK, ST_WLINK, ST_PTYPE, ST_WTYPE, ST_PTEMP, ST_WTEMP,
        ST_PDATA, ST_WDATA, ST_DONE
    } state_e;

    state_e                        state;
    state_e                        next_state;
    logic                          launch;
    logic                          prep;
    logic [$clog2(`PKT_COUNT)-1:0] seq_cnt;
    logic [3:0]                    seq_hdr;
    logic [7:0]                    link_id_q;
    logic [7:0]                    dev_type_q;
    logic [7:0]                    temp_q;
    logic [3:0]                    didx_q;
    logic [7:0]                    len_q;
    logic [`PKT_RAM_AW-1:0]        ram_base_q;

    assign launch     = (state == ST_IDLE) && start;
    assign prep       = state inside {ST_PACK, ST_PNAK, ST_PSTALL, ST_PLINK,
                                      ST_PTYPE, ST_PTEMP, ST_PDATA};
    assign seq_hdr    = 4'(seq_cnt);
    assign fill_start = launch;
    assign busy       = (state != ST_IDLE);
    assign done       = (state == ST_DONE);

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:   if (start) next_state = ST_FILL;
            ST_FILL:   if (fill_done) next_state = ST_PACK;
            ST_PACK:   next_state = ST_WACK;
            ST_WACK:   if (tx_done) next_state = ST_PNAK;
            ST_PNAK:   next_state = ST_WNAK;
            ST_WNAK:   if (tx_done) next_state = ST_PSTALL;
            ST_PSTALL: next_state = ST_WSTALL;
            ST_WSTALL: if (tx_done) next_state = ST_PLINK;
            ST_PLINK:  next_state = ST_WLINK;
            ST_WLINK:  if (tx_done) next_state = ST_PTYPE;
            ST_PTYPE:  next_state = ST_WTYPE;
            ST_WTYPE:  if (tx_done) next_state = ST_PTEMP;
            ST_PTEMP:  next_state = ST_WTEMP;
            ST_WTEMP:  if (tx_done) next_state = ST_PDATA;
            ST_PDATA:  next_state = ST_WDATA;
            ST_WDATA:  if (tx_done) next_state = ST_DONE;
            default:   next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            tx_start <= 1'b0;
            seq_cnt  <= '0;
        end else begin
            state    <= next_state;
            tx_start <= prep;
            if (launch) begin
                seq_cnt <= '0;
            end else if (prep) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
        end
    end

    // Request fields. Non-payload kinds carry seq in the didx slot.
    always_ff @(posedge clk) begin
        if (launch) begin
            link_id_q  <= link_id;
            dev_type_q <= dev_type;
            temp_q     <= temp;
            didx_q     <= didx;
            len_q      <= len;
            ram_base_q <= ram_base;
        end
        req.ram_base <= ram_base_q;
        case (state)
            ST_PACK: begin
                req.hdr.ctrl <= '{kind: pkt_pkg::KIND_ACK, seq: seq_hdr, code: 8'h00};
                req.field    <= 8'h00;
            end
            ST_PNAK: begin
                req.hdr.ctrl <= '{kind: pkt_pkg::KIND_NAK, seq: seq_hdr, code: 8'hFF};
                req.field    <= 8'h00;
            end
            ST_PSTALL: begin
                req.hdr.ctrl <= '{kind: pkt_pkg::KIND_STALL, seq: seq_hdr, code: 8'h55};
                req.field    <= 8'h00;
            end
            ST_PLINK: begin
                req.hdr.data <= '{kind: pkt_pkg::KIND_LINK, didx: seq_hdr, len: 8'd1};
                req.field    <= link_id_q;
            end
            ST_PTYPE: begin
                req.hdr.data <= '{kind: pkt_pkg::KIND_TYPE, didx: seq_hdr, len: 8'd1};
                req.field    <= dev_type_q;
            end
            ST_PTEMP: begin
                req.hdr.data <= '{kind: pkt_pkg::KIND_TEMP, didx: seq_hdr, len: 8'd1};
                req.field    <= temp_q;
            end
            ST_PDATA: begin
                req.hdr.data <= '{kind: pkt_pkg::KIND_DATA0, didx: didx_q, len: len_q};
                req.field    <= 8'h00;
            end
            default: begin
                req.hdr <= req.hdr;
            end
        endcase
    end

endmodule

// ==== verilog/frame_tx_top.sv ====
`include "pkt_macros.svh"

module frame_tx_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [7:0]             fill_seed,
    input  logic [7:0]             link_id,
    input  logic [7:0]             dev_type,
    input  logic [7:0]             temp,
    input  logic [3:0]             didx,
    input  logic [7:0]             len,
    input  logic [`PKT_RAM_AW-1:0] ram_base,
    output logic [7:0]             txd,
    output logic                   txv,
    output logic                   busy,
    output logic                   done
);

    logic                   fill_start;
    logic                   fill_done;
    logic                   tx_start;
    logic                   tx_done;
    pkt_pkg::pkt_req_t      req;
    logic                   wr_en;
    logic [`PKT_RAM_AW-1:0] wr_addr;
    logic [7:0]             wr_data;
    logic [`PKT_RAM_AW-1:0] rd_addr;
    logic [7:0]             rd_data;

    frame_sequencer u_seq (
        .clk(clk), .rst(rst), .start(start),
        .link_id(link_id), .dev_type(dev_type), .temp(temp),
        .didx(didx), .len(len), .ram_base(ram_base),
        .fill_start(fill_start), .fill_done(fill_done),
        .tx_start(tx_start), .req(req), .tx_done(tx_done),
        .busy(busy), .done(done)
    );

    ram_fill u_fill (
        .clk(clk), .rst(rst), .fill_start(fill_start), .fill_seed(fill_seed),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .fill_done(fill_done)
    );

    frame_ram u_ram (
        .clk(clk), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    frame_tx u_tx (
        .clk(clk), .rst(rst), .tx_start(tx_start), .req(req),
        .rd_addr(rd_addr), .rd_data(rd_data),
        .txd(txd), .txv(txv), .tx_done(tx_done)
    );

endmodule

// ==== tests/frame_tx_assertions.sv ====
`include "pkt_macros.svh"

module frame_tx_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   start,
    input logic [7:0]             fill_seed,
    input logic [7:0]             link_id,
    input logic [7:0]             dev_type,
    input logic [7:0]             temp,
    input logic [3:0]             didx,
    input logic [7:0]             len,
    input logic [`PKT_RAM_AW-1:0] ram_base,
    input logic [7:0]             txd,
    input logic                   txv,
    input logic                   busy,
    input logic                   done
);

    timeunit 1ns;
    timeprecision 1ps;

    int                     errors = 0;
    logic                   in_run;
    logic [3:0]             pkt_idx;
    logic [8:0]             pos;
    logic [8:0]             last_pos;
    logic [7:0]             csum;
    logic [11:0]            kc;
    logic [7:0]             exp_byte;
    logic [7:0]             seed_q;
    logic [7:0]             link_q;
    logic [7:0]             type_q;
    logic [7:0]             temp_q;
    logic [3:0]             didx_q;
    logic [7:0]             len_q;
    logic [`PKT_RAM_AW-1:0] base_q;

    // Kind and header low byte for each packet slot of a run.
    function automatic logic [11:0] kind_and_low(input logic [3:0] idx);
        case (idx)
            4'd0:    return {pkt_pkg::KIND_ACK, 8'h00};
            4'd1:    return {pkt_pkg::KIND_NAK, 8'hFF};
            4'd2:    return {pkt_pkg::KIND_STALL, 8'h55};
            4'd3:    return {pkt_pkg::KIND_LINK, 8'h01};
            4'd4:    return {pkt_pkg::KIND_TYPE, 8'h01};
            4'd5:    return {pkt_pkg::KIND_TEMP, 8'h01};
            default: return {pkt_pkg::KIND_DATA0, 8'h00};
        endcase
    endfunction

    always_comb begin
        kc = kind_and_low(pkt_idx);
        if (pkt_idx < 4'd3) begin
            last_pos = 9'd3;
        end else if (pkt_idx < 4'd6) begin
            last_pos = 9'd4;
        end else begin
            last_pos = 9'd3 + {1'b0, len_q};
        end
        if (pos == 9'd0) begin
            exp_byte = `PKT_SYNC;
        end else if (pos == 9'd1) begin
            exp_byte = {kc[11:8], (pkt_idx == 4'd6) ? didx_q : pkt_idx};
        end else if (pos == 9'd2) begin
            exp_byte = (pkt_idx == 4'd6) ? len_q : kc[7:0];
        end else if (pos == last_pos) begin
            exp_byte = csum;
        end else if (pkt_idx == 4'd6) begin
            // Payload wraps around the top of the RAM.
            exp_byte = 8'(base_q + 8'(pos - 9'd3)) + seed_q;
        end else begin
            exp_byte = (pkt_idx == 4'd3) ? link_q : (pkt_idx == 4'd4) ? type_q : temp_q;
        end
    end

    // Byte position within the packet and packet slot within the run.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_run  <= 1'b0;
            pkt_idx <= '0;
            pos     <= '0;
            csum    <= '0;
        end else begin
            if (txv) begin
                if (pos == last_pos) begin
                    pos     <= '0;
                    pkt_idx <= pkt_idx + 4'd1;
                end else begin
                    pos <= pos + 9'd1;
                end
                if (pos == 9'd1) begin
                    csum <= txd;
                end else if (pos != 9'd0) begin
                    csum <= csum ^ txd;
                end
            end
            if (done) begin
                in_run <= 1'b0;
            end else if (start && !in_run) begin
                in_run  <= 1'b1;
                pkt_idx <= '0;
                pos     <= '0;
            end
        end
    end

    // Run parameters as captured at launch.
    always_ff @(posedge clk) begin
        if (start && !in_run) begin
            seed_q <= fill_seed;
            link_q <= link_id;
            type_q <= dev_type;
            temp_q <= temp;
            didx_q <= didx;
            len_q  <= len;
            base_q <= ram_base;
        end
    end

    a_sync: assert property (@(posedge clk) disable iff (rst)
        (txv && pos == 9'd0) |-> (txd == exp_byte))
    else begin
        errors = errors + 1;
        $error("MISMATCH txd sync: got %h expected %h", $sampled(txd), `PKT_SYNC);
    end

    a_header: assert property (@(posedge clk) disable iff (rst)
        (txv && (pos == 9'd1 || pos == 9'd2)) |-> (txd == exp_byte))
    else begin
        errors = errors + 1;
        $error("MISMATCH txd header: got %h expected %h", $sampled(txd), $sampled(exp_byte));
    end

    a_body: assert property (@(posedge clk) disable iff (rst)
        (txv && pos >= 9'd3 && pos < last_pos) |-> (txd == exp_byte))
    else begin
        errors = errors + 1;
        $error("MISMATCH txd body: got %h expected %h", $sampled(txd), $sampled(exp_byte));
    end

    a_csum: assert property (@(posedge clk) disable iff (rst)
        (txv && pos == last_pos) |-> (txd == exp_byte))
    else begin
        errors = errors + 1;
        $error("MISMATCH txd checksum: got %h expected %h", $sampled(txd), $sampled(csum));
    end

    a_busy: assert property (@(posedge clk) disable iff (rst)
        busy == in_run)
    else begin
        errors = errors + 1;
        $error("MISMATCH busy: got %h expected %h", $sampled(busy), $sampled(in_run));
    end

    a_txv: assert property (@(posedge clk) disable iff (rst)
        txv |-> (busy && pkt_idx < 4'(`PKT_COUNT)))
    else begin
        errors = errors + 1;
        $error("txv was high outside the seven packets of a busy run");
    end

    a_done: assert property (@(posedge clk) disable iff (rst)
        done |-> (in_run && pkt_idx == 4'(`PKT_COUNT) && pos == 9'd0))
    else begin
        errors = errors + 1;
        $error("done pulsed without seven complete packets in the current run");
    end

endmodule

// ==== tests/frame_tx_tb.sv ====
`include "pkt_macros.svh"

module frame_tx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RUNS = 8;
    // A run takes at most about 560 cycles.
    localparam int MAX_CYCLES = RUNS * 900 + 20;

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic [7:0]             fill_seed;
    logic [7:0]             link_id;
    logic [7:0]             dev_type;
    logic [7:0]             temp;
    logic [3:0]             didx;
    logic [7:0]             len;
    logic [`PKT_RAM_AW-1:0] ram_base;
    logic [7:0]             txd;
    logic                   txv;
    logic                   busy;
    logic                   done;
    logic [31:0]            lfsr;
    int                     cycles;

    frame_tx_top uut (
        .clk(clk), .rst(rst), .start(start), .fill_seed(fill_seed),
        .link_id(link_id), .dev_type(dev_type), .temp(temp), .didx(didx),
        .len(len), .ram_base(ram_base), .txd(txd), .txv(txv),
        .busy(busy), .done(done)
    );

    bind frame_tx_top frame_tx_assertions chk (
        .clk(clk), .rst(rst), .start(start), .fill_seed(fill_seed),
        .link_id(link_id), .dev_type(dev_type), .temp(temp), .didx(didx),
        .len(len), .ram_base(ram_base), .txd(txd), .txv(txv),
        .busy(busy), .done(done)
    );

    always #20 clk = ~clk;

    // Galois form with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic draw_inputs(input logic wrap);
        logic [31:0] v;
        take_bits(8, v);
        fill_seed <= v[7:0];
        take_bits(8, v);
        link_id <= v[7:0];
        take_bits(8, v);
        dev_type <= v[7:0];
        take_bits(8, v);
        temp <= v[7:0];
        take_bits(4, v);
        didx <= v[3:0];
        take_bits(8, v);
        len <= (v[7:0] == 8'd0) ? 8'd1 : v[7:0];
        take_bits(`PKT_RAM_AW, v);
        ram_base <= v[`PKT_RAM_AW-1:0];
        // Longest payload so the read address crosses 0xFF.
        if (wrap) begin
            len      <= 8'd255;
            ram_base <= 8'hF0;
        end
    endtask

    task automatic pulse_start();
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (done !== 1'b1);
    endtask

    // Inputs change right after launch.
    // Extra starts land in the fill and in the packets.
    task automatic do_run(input logic wrap, input logic restart);
        @(posedge clk);
        draw_inputs(wrap);
        pulse_start();
        draw_inputs(1'b0);
        if (restart) begin
            repeat (100) @(posedge clk);
            pulse_start();
            draw_inputs(1'b0);
            repeat (180) @(posedge clk);
            pulse_start();
        end
        wait_done();
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "Timeout: done never came within %0d cycles", MAX_CYCLES);
        end
    end

    always @(negedge clk) begin
        if (uut.chk.errors != 0) begin
            $display("SOME TESTS FAILED");
            $fatal(1, "A check in the bound checker failed");
        end
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        start     = 1'b0;
        fill_seed = '0;
        link_id   = '0;
        dev_type  = '0;
        temp      = '0;
        didx      = '0;
        len       = 8'd1;
        ram_base  = '0;
        lfsr      = 32'h95eb_e7cb;
        cycles    = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < RUNS; r++) begin
            do_run(r == 2, r == 5);
        end
        repeat (4) @(negedge clk);
        if (uut.chk.errors == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "Checker reported failures");
        end
    end

endmodule

// ==== src.f ====
+incdir+verilog
verilog/pkt_pkg.sv
verilog/frame_ram.sv
verilog/ram_fill.sv
verilog/frame_tx.sv
verilog/frame_sequencer.sv
verilog/frame_tx_top.sv
tests/frame_tx_assertions.sv
tests/frame_tx_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= frame_tx_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
